// File: src/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// ============================================================
	// Host DMA and memory port widths
	// ============================================================

	localparam int MEM_ADDR_W = 32;
	localparam int MEM_DATA_W = 32;

	// Byte address, same on the host DMA side and the memory side
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// One data word per transfer
	typedef logic [MEM_DATA_W-1:0] mem_data_t;

	// ============================================================
	// DMA bridge FSM
	// ============================================================

	typedef enum logic [2:0] {
		idle,
		read_issue,
		read_wait,
		write_issue,
		write_done
	} bridge_state_t;

endpackage

`default_nettype wire

// File: src/board_pkg.sv
`default_nettype none

package board_pkg;

	// ============================================================
	// Audio path
	// ============================================================

	localparam int SAMPLE_W = 16;

	// Signed PCM sample as delivered by the sound block
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Level added on top of the halved sample while the PC speaker is high
	localparam sample_t SPEAKER_LEVEL = 16'h7fff;

endpackage

`default_nettype wire

// File: src/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
	parameter int RESET_PULSE_CYCLES = 8
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic soft_reset_req,
	input  logic button_reset,
	input  logic kbd_reset_n,
	output logic sys_reset,
	output logic cpu_reset
);

	// Two-stage synchroniser plus one delay stage for edge detection
	logic soft_sync_1;
	logic soft_sync_2;
	logic soft_sync_3;
	logic soft_edge;

	// Ones shift out of the top, one per cycle
	logic [RESET_PULSE_CYCLES-1:0] pulse_sr;

	// Set once the host has released the system for the first time
	logic initialised;

	logic cpu_req_q;

	assign soft_edge = soft_sync_2 & ~soft_sync_3;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			soft_sync_1 <= 1'b0;
			soft_sync_2 <= 1'b0;
			soft_sync_3 <= 1'b0;
			pulse_sr    <= '0;
			initialised <= 1'b0;
			cpu_req_q   <= 1'b0;
		end else begin
			soft_sync_1 <= soft_reset_req;
			soft_sync_2 <= soft_sync_1;
			soft_sync_3 <= soft_sync_2;

			// Any reset source from buttons, host or keyboard controller
			cpu_req_q <= button_reset | soft_reset_req | ~kbd_reset_n;

			if (soft_edge) begin
				pulse_sr    <= '1;
				initialised <= 1'b1;
			end else begin
				pulse_sr <= pulse_sr << 1;
			end
		end
	end

	// System stays in reset until the first soft reset completes
	assign sys_reset = pulse_sr[RESET_PULSE_CYCLES-1] | ~initialised | reset;
	assign cpu_reset = sys_reset | cpu_req_q;

endmodule

`default_nettype wire

// File: src/dma_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module dma_mem_bridge
	import mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,

	// Host DMA side
	input  logic      dma_rd,
	input  logic      dma_wr,
	input  mem_addr_t dma_addr,
	input  mem_data_t dma_dout,
	output mem_data_t dma_din,
	output logic      host_wait,

	// Memory port
	output mem_addr_t mem_address,
	output mem_data_t mem_writedata,
	output logic      mem_read,
	output logic      mem_write,
	input  logic      mem_waitrequest,
	input  mem_data_t mem_readdata,
	input  logic      mem_readdatavalid
);

	bridge_state_t state;

	logic host_free;
	logic req_take;
	logic rd_capture;

	// In write_done the write is already accepted and the host may issue again
	assign host_free  = (state == idle) || (state == write_done);
	assign req_take   = host_free & (dma_rd | dma_wr);
	assign rd_capture = (state == read_wait) & mem_readdatavalid;

	// ============================================================
	// Transfer FSM
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle, write_done: begin
					if (dma_rd) begin
						state <= read_issue;
					end else if (dma_wr) begin
						state <= write_issue;
					end else begin
						state <= idle;
					end
				end

				// Command held until the memory drops waitrequest
				read_issue: begin
					if (!mem_waitrequest) begin
						state <= read_wait;
					end
				end

				read_wait: begin
					if (mem_readdatavalid) begin
						state <= idle;
					end
				end

				write_issue: begin
					if (!mem_waitrequest) begin
						state <= write_done;
					end
				end

				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// ============================================================
	// Request and read data capture
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (req_take) begin
			mem_address   <= dma_addr;
			mem_writedata <= dma_dout;
		end

		if (rd_capture) begin
			dma_din <= mem_readdata;
		end
	end

	// Outputs decode straight from the state register
	assign mem_read  = (state == read_issue);
	assign mem_write = (state == write_issue);
	assign host_wait = ~host_free;

endmodule

`default_nettype wire

// File: src/activity_led.sv
`timescale 1ns/1ps
`default_nettype none

module activity_led #(
	parameter int STRETCH_CYCLES = 4500000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic busy,
	output logic led
);

	localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

	// Remaining hold cycles after the current one
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
			led   <= 1'b0;
		end else if (busy) begin
			// Retrigger on every busy cycle
			count <= CNT_W'(STRETCH_CYCLES - 1);
			led   <= 1'b1;
		end else if (count != '0) begin
			count <= count - CNT_W'(1);
			led   <= 1'b1;
		end else begin
			led <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/audio_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module audio_mixer
	import board_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  sample_t sb_left,
	input  sample_t sb_right,
	input  logic    speaker_ena,
	input  logic    speaker_out,
	output sample_t audio_left,
	output sample_t audio_right
);

	logic spk_on;

	// Halve for headroom, then add the speaker square wave
	function automatic sample_t mix(input sample_t sample, input logic spk);
		sample_t half;
		half = sample >>> 1;
		return spk ? sample_t'(half + SPEAKER_LEVEL) : half;
	endfunction

	assign spk_on = speaker_ena & speaker_out;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_left  <= '0;
			audio_right <= '0;
		end else begin
			audio_left  <= mix(sb_left, spk_on);
			audio_right <= mix(sb_right, spk_on);
		end
	end

endmodule

`default_nettype wire

// File: src/emu_glue_top.sv
`timescale 1ns/1ps
`default_nettype none

module emu_glue_top
	import mem_pkg::*;
	import board_pkg::*;
#(
	parameter int RESET_PULSE_CYCLES = 8,
	parameter int STRETCH_CYCLES     = 4500000
) (
	input  logic      clk_sys,
	input  logic      reset,

	// Host control
	input  logic      soft_reset_req,
	input  logic      button_reset,
	input  logic      kbd_reset_n,

	// Host DMA
	input  logic      dma_rd,
	input  logic      dma_wr,
	input  mem_addr_t dma_addr,
	input  mem_data_t dma_dout,
	input  logic      disk_device,
	output mem_data_t dma_din,
	output logic      host_wait,

	// Memory port
	output mem_addr_t mem_address,
	output mem_data_t mem_writedata,
	output logic      mem_read,
	output logic      mem_write,
	input  logic      mem_waitrequest,
	input  mem_data_t mem_readdata,
	input  logic      mem_readdatavalid,

	// Audio
	input  sample_t   sb_left,
	input  sample_t   sb_right,
	input  logic      speaker_ena,
	input  logic      speaker_out,
	output sample_t   audio_left,
	output sample_t   audio_right,

	// Status
	output logic      sys_reset,
	output logic      cpu_reset,
	output logic      led_disk,
	output logic      led_floppy
);

	logic disk_busy;
	logic floppy_busy;

	// ============================================================
	// Reset and DMA path
	// ============================================================

	reset_sequencer #(
		.RESET_PULSE_CYCLES(RESET_PULSE_CYCLES)
	) u_reset_sequencer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.soft_reset_req (soft_reset_req),
		.button_reset   (button_reset),
		.kbd_reset_n    (kbd_reset_n),
		.sys_reset      (sys_reset),
		.cpu_reset      (cpu_reset)
	);

	// Bridge runs from the board reset so host DMA works while the system is held
	dma_mem_bridge u_dma_mem_bridge (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.dma_rd            (dma_rd),
		.dma_wr            (dma_wr),
		.dma_addr          (dma_addr),
		.dma_dout          (dma_dout),
		.dma_din           (dma_din),
		.host_wait         (host_wait),
		.mem_address       (mem_address),
		.mem_writedata     (mem_writedata),
		.mem_read          (mem_read),
		.mem_write         (mem_write),
		.mem_waitrequest   (mem_waitrequest),
		.mem_readdata      (mem_readdata),
		.mem_readdatavalid (mem_readdatavalid)
	);

	// ============================================================
	// Activity LEDs and audio
	// ============================================================

	assign disk_busy   = disk_device & host_wait;
	assign floppy_busy = ~disk_device & host_wait;

	activity_led #(
		.STRETCH_CYCLES(STRETCH_CYCLES)
	) u_led_disk (
		.clk_sys (clk_sys),
		.reset   (reset),
		.busy    (disk_busy),
		.led     (led_disk)
	);

	activity_led #(
		.STRETCH_CYCLES(STRETCH_CYCLES)
	) u_led_floppy (
		.clk_sys (clk_sys),
		.reset   (reset),
		.busy    (floppy_busy),
		.led     (led_floppy)
	);

	audio_mixer u_audio_mixer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sb_left     (sb_left),
		.sb_right    (sb_right),
		.speaker_ena (speaker_ena),
		.speaker_out (speaker_out),
		.audio_left  (audio_left),
		.audio_right (audio_right)
	);

endmodule

`default_nettype wire

// File: verif/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model
	import mem_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  mem_addr_t mem_address,
	input  mem_data_t mem_writedata,
	input  logic      mem_read,
	input  logic      mem_write,
	input  logic      rnd_wait,
	input  logic [1:0] rnd_lat,
	output logic      mem_waitrequest,
	output mem_data_t mem_readdata,
	output logic      mem_readdatavalid
);

	mem_data_t words [mem_addr_t];
	logic      wait_q = 1'b0;
	logic      valid_q = 1'b0;
	mem_data_t rdata_q = '0;
	logic      pend = 1'b0;
	logic [1:0] lat = 2'd0;
	mem_addr_t raddr = '0;

	// Unwritten words read back as a pattern of the full address
	function automatic mem_data_t read_word(input mem_addr_t a);
		return words.exists(a) ? words[a] : (a ^ 32'ha5a5a5a5);
	endfunction

	assign mem_waitrequest   = wait_q;
	assign mem_readdata      = rdata_q;
	assign mem_readdatavalid = valid_q;

	always @(posedge clk_sys) begin
		valid_q <= 1'b0;
		if (reset) begin
			wait_q <= 1'b0;
			pend   = 1'b0;
		end else begin
			if (mem_write && !wait_q) begin
				words[mem_address] = mem_writedata;
			end
			if (mem_read && !wait_q) begin
				pend  = 1'b1;
				lat   = rnd_lat;
				raddr = mem_address;
			end else if (pend) begin
				if (lat == 2'd0) begin
					valid_q <= 1'b1;
					rdata_q <= read_word(raddr);
					pend = 1'b0;
				end else begin
					lat = lat - 2'd1;
				end
			end
			wait_q <= rnd_wait;
		end
	end

endmodule

`default_nettype wire

// File: verif/emu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module emu_checker
	import mem_pkg::*;
	import board_pkg::*;
#(
	parameter int RESET_PULSE_CYCLES = 8,
	parameter int STRETCH_CYCLES     = 20
) (
	input  logic      clk_sys, reset, soft_reset_req, button_reset, kbd_reset_n,
	input  logic      dma_rd, dma_wr, disk_device, host_wait,
	input  mem_addr_t dma_addr, mem_address,
	input  mem_data_t dma_dout, dma_din, mem_writedata,
	input  logic      mem_read, mem_write, mem_waitrequest, mem_readdatavalid,
	input  sample_t   sb_left, sb_right, audio_left, audio_right,
	input  logic      speaker_ena, speaker_out,
	input  logic      sys_reset, cpu_reset, led_disk, led_floppy,
	output int        error_count,
	output int        done_count
);

	mem_data_t shadow [mem_addr_t];
	logic armed = 1'b0;
	logic s1 = 1'b0, s2 = 1'b0, s3 = 1'b0, init = 1'b0, cpu_q = 1'b0;
	logic exp_sys, edge_seen;
	int   cnt = 0, rem_disk = 0, rem_floppy = 0;
	sample_t exp_left = '0, exp_right = '0;
	logic stall = 1'b0, wait_rise = 1'b0, prev_wait = 1'b0;
	logic req_wr = 1'b0, accepted = 1'b0, got_data = 1'b0;
	mem_addr_t req_addr = '0;
	mem_data_t req_data = '0;
	logic [65:0] stall_snap = '0;

	initial begin
		error_count = 0;
		done_count  = 0;
	end

	// Arithmetic halving plus speaker level with 16-bit wrap
	function automatic sample_t mix_ref(input sample_t s, input logic spk);
		sample_t h;
		h = {s[15], s[15:1]};
		return spk ? sample_t'(h + SPEAKER_LEVEL) : h;
	endfunction

	function automatic mem_data_t mem_expect(input mem_addr_t a);
		return shadow.exists(a) ? shadow[a] : (a ^ 32'ha5a5a5a5);
	endfunction

	function automatic int led_next(input int rem, input logic busy, input logic rst);
		if (rst) return 0;
		if (busy) return STRETCH_CYCLES;
		return (rem > 0) ? rem - 1 : 0;
	endfunction

	task automatic fail(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		error_count++;
	endtask

	always @(posedge clk_sys) begin
		exp_sys = reset | ~init | (cnt != 0);
		if (armed) begin
			// ============================================================
			// Reset, LEDs and audio
			// ============================================================
			if (sys_reset !== exp_sys) fail($sformatf("sys_reset %b", sys_reset));
			if (cpu_reset !== (exp_sys | cpu_q)) fail($sformatf("cpu_reset %b", cpu_reset));
			if (led_disk !== (rem_disk != 0)) fail("led_disk mismatch");
			if (led_floppy !== (rem_floppy != 0)) fail("led_floppy mismatch");
			if (audio_left !== exp_left)
				fail($sformatf("audio_left %h exp %h", audio_left, exp_left));
			if (audio_right !== exp_right)
				fail($sformatf("audio_right %h exp %h", audio_right, exp_right));

			// ============================================================
			// Memory port and host wait
			// ============================================================
			if (stall && ({mem_read, mem_write, mem_address, mem_writedata} !== stall_snap))
				fail("memory command changed while stalled");
			if (wait_rise && !host_wait) fail("host_wait did not rise after request");
			if ((mem_read | mem_write) && !mem_waitrequest) begin
				if (accepted) fail("second command accepted for one request");
				if (mem_address !== req_addr || mem_write !== req_wr ||
					(req_wr && mem_writedata !== req_data))
					fail($sformatf("command addr %h data %h", mem_address, mem_writedata));
				accepted = 1'b1;
				if (req_wr) shadow[req_addr] = req_data;
			end
			if (mem_readdatavalid && !req_wr) got_data = 1'b1;
			if (prev_wait && !host_wait) begin
				done_count++;
				if (!accepted || (!req_wr && !got_data)) fail("host_wait fell early");
				if (!req_wr && dma_din !== mem_expect(req_addr))
					fail($sformatf("read %h got %h exp %h", req_addr, dma_din,
						mem_expect(req_addr)));
			end
		end

		// Model state for the next cycle
		stall      = (mem_read | mem_write) & mem_waitrequest;
		stall_snap = {mem_read, mem_write, mem_address, mem_writedata};
		prev_wait  = host_wait;
		wait_rise  = dma_rd | dma_wr;
		if (dma_rd | dma_wr) begin
			req_wr   = dma_wr;
			req_addr = dma_addr;
			req_data = dma_dout;
			accepted = 1'b0;
			got_data = 1'b0;
		end
		rem_disk   = led_next(rem_disk, disk_device & host_wait, reset);
		rem_floppy = led_next(rem_floppy, ~disk_device & host_wait, reset);
		exp_left   = reset ? sample_t'(0) : mix_ref(sb_left, speaker_ena & speaker_out);
		exp_right  = reset ? sample_t'(0) : mix_ref(sb_right, speaker_ena & speaker_out);
		edge_seen  = s2 & ~s3;
		if (reset) begin
			{s1, s2, s3, init, cpu_q} = '0;
			cnt = 0;
		end else begin
			cpu_q = button_reset | soft_reset_req | ~kbd_reset_n;
			s3 = s2;
			s2 = s1;
			s1 = soft_reset_req;
			if (edge_seen) begin
				cnt  = RESET_PULSE_CYCLES;
				init = 1'b1;
			end else if (cnt > 0) begin
				cnt = cnt - 1;
			end
		end
		if (reset) armed = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/tb_emu_glue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_emu_glue;
	import mem_pkg::*;
	import board_pkg::*;

	localparam int RESET_PULSE_CYCLES = 8;
	localparam int STRETCH_CYCLES     = 20;
	localparam int N_WORDS            = 24;
	localparam int N_XFER             = 2 * N_WORDS;

	logic clk_sys = 1'b0, reset = 1'b1;
	logic soft_reset_req = 1'b0, button_reset = 1'b0, kbd_reset_n = 1'b1;
	logic dma_rd = 1'b0, dma_wr = 1'b0, disk_device = 1'b0;
	mem_addr_t dma_addr = '0;
	mem_data_t dma_dout = '0;
	sample_t sb_left = '0, sb_right = '0;
	logic speaker_ena = 1'b0, speaker_out = 1'b0;
	logic rnd_wait = 1'b0;
	logic [1:0] rnd_lat = 2'd0;
	logic [31:0] stim_state = 32'h88a3;
	logic [31:0] bg_state = 32'h88a3;
	int issued = 0;
	int error_count, done_count;

	mem_data_t dma_din, mem_writedata, mem_readdata;
	mem_addr_t mem_address;
	logic host_wait, mem_read, mem_write, mem_waitrequest, mem_readdatavalid;
	logic sys_reset, cpu_reset, led_disk, led_floppy;
	sample_t audio_left, audio_right;

	always #5 clk_sys = ~clk_sys;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v  = {v[30:0], st[31]};
			st = lfsr_step(st);
		end
	endtask

	// Memory timing and audio inputs change every cycle
	always @(posedge clk_sys) begin
		logic [31:0] v;
		take_bits(bg_state, 3, v);
		rnd_wait <= v[2];
		rnd_lat  <= v[1:0];
		take_bits(bg_state, 32, v);
		sb_left  <= v[15:0];
		sb_right <= v[31:16];
		take_bits(bg_state, 2, v);
		speaker_ena <= v[1];
		speaker_out <= v[0];
	end

	task automatic transfer(input logic is_write);
		logic [31:0] v;
		@(posedge clk_sys);
		while (host_wait) @(posedge clk_sys);
		take_bits(stim_state, 4, v);
		dma_addr <= {26'h40, v[3:0], 2'b00};
		take_bits(stim_state, 32, v);
		dma_dout <= v;
		take_bits(stim_state, 1, v);
		disk_device <= v[0];
		dma_wr <= is_write;
		dma_rd <= ~is_write;
		@(posedge clk_sys);
		dma_wr <= 1'b0;
		dma_rd <= 1'b0;
		issued++;
	endtask

	emu_glue_top #(
		.RESET_PULSE_CYCLES(RESET_PULSE_CYCLES),
		.STRETCH_CYCLES    (STRETCH_CYCLES)
	) u_emu_glue_top (.*);

	mem_model u_mem_model (.*);

	emu_checker #(
		.RESET_PULSE_CYCLES(RESET_PULSE_CYCLES),
		.STRETCH_CYCLES    (STRETCH_CYCLES)
	) u_emu_checker (.*);

	// ============================================================
	// Stimulus
	// ============================================================

	initial begin
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (10) @(posedge clk_sys);
		soft_reset_req <= 1'b1;
		repeat (3) @(posedge clk_sys);
		soft_reset_req <= 1'b0;
		repeat (RESET_PULSE_CYCLES + 8) @(posedge clk_sys);
		button_reset <= 1'b1;
		@(posedge clk_sys);
		button_reset <= 1'b0;
		kbd_reset_n  <= 1'b0;
		@(posedge clk_sys);
		kbd_reset_n <= 1'b1;
		for (int i = 0; i < N_WORDS; i++) transfer(1'b1);
		for (int i = 0; i < N_WORDS; i++) transfer(1'b0);
		@(posedge clk_sys);
		while (host_wait) @(posedge clk_sys);
		repeat (STRETCH_CYCLES + 5) @(posedge clk_sys);
		$display("errors=%0d missing completions=%0d", error_count, issued - done_count);
		if (error_count == 0 && done_count == issued) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(200 * N_XFER + 5000);
		$display("Timeout: %0d of %0d transfers completed", done_count, issued);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
src/mem_pkg.sv
src/board_pkg.sv
src/reset_sequencer.sv
src/dma_mem_bridge.sv
src/activity_led.sv
src/audio_mixer.sv
src/emu_glue_top.sv
verif/mem_model.sv
verif/emu_checker.sv
verif/tb_emu_glue.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_emu_glue
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
